// ==== Bender.yml ====
package:
  name: evg

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/evg_pkg.sv
      - hdl/evg_sync_fifo.sv
      - hdl/evg_test_pattern.sv
      - hdl/evg_frame_gen.sv
      - hdl/evg_apb_regs.sv
      - hdl/evg_top.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - sim/evg_checker.sv
      - sim/tb_evg.sv

// ==== hdl/evg_apb_regs.sv ====
`timescale 1ns/1ps
`include "evg_defines.svh"

module evg_apb_regs
    import evg_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  evg_apb_req_t         apb_req_i,
    output evg_apb_rsp_t         apb_rsp_o,
    output logic                 link_en_o,
    output evg_seg_wr_t          seg_wr_o,
    output evg_tp_ctrl_t         tp_ctrl_o,
    output logic                 tp_pop_o,
    input  logic [`EVG_TP_W-1:0] tp_head_i,
    input  evg_tp_stat_t         tp_stat_i
);
    localparam int unsigned SEG_SPAN = `EVG_SEG_WORDS * 4;  // Bytes of SEG window

    logic                    access;
    logic                    wr;
    logic                    rd;
    logic                    hit_ctrl;
    logic                    hit_presc;
    logic                    hit_status;
    logic                    hit_tp;
    logic                    hit_seg;
    logic                    mapped;
    logic                    ro_write;
    logic [`EVG_APB_AW-1:0]  seg_off;
    logic [SEG_IDX_W-1:0]    seg_idx;
    logic                    tp_en;
    logic [`EVG_PRESC_W-1:0] presc;
    logic [31:0]             seg_shadow [`EVG_SEG_WORDS];  // Read-back copy
    logic [31:0]             rdata;

    // Access phase, zero wait
    assign access = apb_req_i.psel && apb_req_i.penable;
    assign wr     = access && apb_req_i.pwrite;
    assign rd     = access && !apb_req_i.pwrite;

    // Address decode
    assign hit_ctrl   = (apb_req_i.paddr == `EVG_REG_CTRL);
    assign hit_presc  = (apb_req_i.paddr == `EVG_REG_PRESC);
    assign hit_status = (apb_req_i.paddr == `EVG_REG_STATUS);
    assign hit_tp     = (apb_req_i.paddr == `EVG_REG_TP_DATA);
    assign seg_off    = apb_req_i.paddr - `EVG_REG_SEG_BASE;
    assign seg_idx    = seg_off[SEG_IDX_W+1:2];
    assign hit_seg    = (apb_req_i.paddr >= `EVG_REG_SEG_BASE)
                     && (seg_off < SEG_SPAN)
                     && (seg_off[1:0] == 2'b00);   // Word aligned only

    assign mapped   = hit_ctrl || hit_presc || hit_status || hit_tp || hit_seg;
    assign ro_write = apb_req_i.pwrite && (hit_status || hit_tp);

    assign apb_rsp_o.pready  = 1'b1;
    assign apb_rsp_o.pslverr = access && (!mapped || ro_write);
    assign apb_rsp_o.prdata  = rdata;

    // Writes land at the edge ending the access phase
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            link_en_o <= 1'b0;
            tp_en     <= 1'b0;
            presc     <= '0;
            for (int w = 0; w < `EVG_SEG_WORDS; w++)
                seg_shadow[w] <= '0;
        end
        else if (wr)
        begin
            if (hit_ctrl)
            begin
                link_en_o <= apb_req_i.pwdata[0];
                tp_en     <= apb_req_i.pwdata[1];
            end
            if (hit_presc)
                presc <= apb_req_i.pwdata[`EVG_PRESC_W-1:0];
            if (hit_seg)
                seg_shadow[seg_idx] <= apb_req_i.pwdata;
        end
    end

    // Strobes to the frame generator and test source
    assign seg_wr_o.en   = wr && hit_seg;
    assign seg_wr_o.idx  = seg_idx;
    assign seg_wr_o.data = apb_req_i.pwdata;

    assign tp_ctrl_o.enable = tp_en;
    assign tp_ctrl_o.clear  = wr && hit_ctrl && apb_req_i.pwdata[2];  // Pulse, not stored
    assign tp_ctrl_o.presc  = presc;

    assign tp_pop_o = rd && hit_tp && !tp_stat_i.empty;  // Pop at end of read

    // Read mux, valid during the access phase
    always_comb
    begin
        rdata = '0;
        if (rd)
        begin
            if (hit_ctrl)
                rdata[1:0] = {tp_en, link_en_o};   // Clear bit reads 0
            else if (hit_presc)
                rdata[`EVG_PRESC_W-1:0] = presc;
            else if (hit_status)
            begin
                rdata[0]              = tp_stat_i.empty;
                rdata[1]              = tp_stat_i.full;
                rdata[8 +: FIFO_CNT_W] = tp_stat_i.count;
            end
            else if (hit_tp && !tp_stat_i.empty)
            begin
                rdata[31]            = 1'b1;       // Valid
                rdata[`EVG_TP_W-1:0] = tp_head_i;
            end
            else if (hit_seg)
                rdata = seg_shadow[seg_idx];
        end
    end

endmodule

// ==== hdl/evg_defines.svh ====
`ifndef EVG_DEFINES_SVH
`define EVG_DEFINES_SVH

// K characters on the link
`define EVG_K28_5        8'hBC   // Comma, event byte
`define EVG_K_START      8'h5C   // Segment start
`define EVG_K_STOP       8'h3C   // Segment stop

// Segment buffer and frame
`define EVG_SEG_BYTES    32
`define EVG_SEG_WORDS    8       // 32-bit APB words over the buffer
`define EVG_FRAME_LEN    64      // Link words per frame

// Test source
`define EVG_TP_W         18
`define EVG_PRESC_W      32
`define EVG_FIFO_DEPTH   16

// APB register map
`define EVG_APB_AW       8
`define EVG_REG_CTRL     8'h00
`define EVG_REG_PRESC    8'h04
`define EVG_REG_STATUS   8'h08   // Read only
`define EVG_REG_TP_DATA  8'h0C   // Read only, read pops
`define EVG_REG_SEG_BASE 8'h40   // First of the segment words

`endif

// ==== hdl/evg_frame_gen.sv ====
`timescale 1ns/1ps
`include "evg_defines.svh"

module evg_frame_gen
    import evg_pkg::*;
(
    input  logic           clk,
    input  logic           rst,
    input  logic           link_en_i,
    input  evg_seg_wr_t    seg_wr_i,
    output evg_link_word_t link_o
);
    localparam int unsigned IDX_W  = $clog2(`EVG_FRAME_LEN);
    localparam int unsigned BYTE_W = $clog2(`EVG_SEG_BYTES);

    logic [31:0]       seg_mem [`EVG_SEG_WORDS];
    logic [IDX_W-1:0]  idx;          // Position in the frame
    logic [BYTE_W-1:0] byte_idx;
    logic [31:0]       seg_word;
    logic [7:0]        ev_byte;
    logic [7:0]        data_byte;
    evg_link_word_t    word_d;       // Word for the current index

    // Segment buffer, only written while the link is down
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int w = 0; w < `EVG_SEG_WORDS; w++)
                seg_mem[w] <= '0;
        end
        else if (seg_wr_i.en)
            seg_mem[seg_wr_i.idx] <= seg_wr_i.data;
    end

    // Odd word i carries buffer byte i/2
    assign byte_idx = idx[IDX_W-1:1];
    assign seg_word = seg_mem[byte_idx[BYTE_W-1:2]];

    always_comb
    begin
        ev_byte   = (idx[1:0] == 2'b00) ? `EVG_K28_5 : 8'h00;     // Comma every 4th word
        data_byte = idx[0] ? seg_word[8*byte_idx[1:0] +: 8] : 8'h00;  // Lowest lane first
        word_d.data = {ev_byte, data_byte};
        // K flags follow the byte values
        word_d.is_k[1] = (ev_byte == `EVG_K28_5);
        word_d.is_k[0] = (data_byte == `EVG_K_START) || (data_byte == `EVG_K_STOP);
    end

    // Sequencer, link_o trails its index by one cycle
    always_ff @(posedge clk)
    begin
        if (rst || !link_en_i)
        begin
            idx    <= '0;          // Restart at the comma
            link_o <= '0;          // Idle link
        end
        else
        begin
            link_o <= word_d;
            if (idx == IDX_W'(`EVG_FRAME_LEN - 1))
                idx <= '0;         // Frame wrap
            else
                idx <= idx + 1'b1;
        end
    end

endmodule

// ==== hdl/evg_pkg.sv ====
`include "evg_defines.svh"

package evg_pkg;

    localparam int unsigned FIFO_CNT_W = $clog2(`EVG_FIFO_DEPTH + 1);  // Holds 0..depth
    localparam int unsigned SEG_IDX_W  = $clog2(`EVG_SEG_WORDS);

    typedef struct packed {
        logic                   psel;
        logic                   penable;
        logic                   pwrite;
        logic [`EVG_APB_AW-1:0] paddr;
        logic [31:0]            pwdata;
    } evg_apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } evg_apb_rsp_t;

    typedef struct packed {
        logic [15:0] data;   // High byte event, low byte data
        logic [1:0]  is_k;   // Bit 1 flags the event byte
    } evg_link_word_t;

    // Segment word write strobe
    typedef struct packed {
        logic                 en;
        logic [SEG_IDX_W-1:0] idx;
        logic [31:0]          data;
    } evg_seg_wr_t;

    typedef struct packed {
        logic                    enable;
        logic                    clear;    // One-cycle pulse
        logic [`EVG_PRESC_W-1:0] presc;
    } evg_tp_ctrl_t;

    typedef struct packed {
        logic                  empty;
        logic                  full;
        logic [FIFO_CNT_W-1:0] count;
    } evg_tp_stat_t;

endpackage

// ==== hdl/evg_sync_fifo.sv ====
`timescale 1ns/1ps
`include "evg_defines.svh"

module evg_sync_fifo
    import evg_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 clear_i,
    input  logic                 push_i,
    input  logic [`EVG_TP_W-1:0] push_data_i,
    input  logic                 pop_i,
    output logic [`EVG_TP_W-1:0] head_o,
    output evg_tp_stat_t         stat_o
);
    localparam int unsigned PTR_W = $clog2(`EVG_FIFO_DEPTH);

    logic [`EVG_TP_W-1:0]  mem [`EVG_FIFO_DEPTH];
    logic [PTR_W-1:0]      wr_ptr;
    logic [PTR_W-1:0]      rd_ptr;
    logic [FIFO_CNT_W-1:0] count;
    logic                  do_push;
    logic                  do_pop;

    assign do_push = push_i && !stat_o.full;   // Push on full is dropped
    assign do_pop  = pop_i && !stat_o.empty;

    assign stat_o.empty = (count == '0);
    assign stat_o.full  = (count == FIFO_CNT_W'(`EVG_FIFO_DEPTH));
    assign stat_o.count = count;
    assign head_o       = mem[rd_ptr];         // Show-ahead head

    // Storage
    always_ff @(posedge clk)
    begin
        if (do_push)
            mem[wr_ptr] <= push_data_i;
    end

    always_ff @(posedge clk)
    begin
        if (rst || clear_i)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_push)
                wr_ptr <= (wr_ptr == PTR_W'(`EVG_FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= (rd_ptr == PTR_W'(`EVG_FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;       // Both or neither
            endcase
        end
    end

endmodule

// ==== hdl/evg_test_pattern.sv ====
`timescale 1ns/1ps
`include "evg_defines.svh"

module evg_test_pattern
    import evg_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  evg_tp_ctrl_t         ctrl_i,
    input  logic                 pop_i,
    output logic [`EVG_TP_W-1:0] head_o,
    output evg_tp_stat_t         stat_o
);
    logic [`EVG_PRESC_W-1:0] cnt;     // Prescaler counter
    logic [`EVG_TP_W-1:0]    value;   // Next value to push
    logic                    run;
    logic                    push;

    // Counting stalls while the FIFO is full, so nothing is lost
    assign run  = ctrl_i.enable && !ctrl_i.clear && !stat_o.full;
    assign push = run && (cnt >= ctrl_i.presc);  // Also catches presc lowered mid-count

    always_ff @(posedge clk)
    begin
        if (rst || ctrl_i.clear)
        begin
            cnt   <= '0;
            value <= '0;
        end
        else if (run)
        begin
            if (push)
            begin
                cnt   <= '0;
                value <= value + 1'b1;
            end
            else
                cnt <= cnt + 1'b1;
        end
    end

    // Clear also empties the FIFO
    evg_sync_fifo u_fifo (
        .clk         (clk),
        .rst         (rst),
        .clear_i     (ctrl_i.clear),
        .push_i      (push),
        .push_data_i (value),
        .pop_i       (pop_i),
        .head_o      (head_o),
        .stat_o      (stat_o)
    );

endmodule

// ==== hdl/evg_top.sv ====
`timescale 1ns/1ps
`include "evg_defines.svh"

module evg_top
    import evg_pkg::*;
(
    input  logic           clk,
    input  logic           rst,
    input  evg_apb_req_t   apb_req_i,
    output evg_apb_rsp_t   apb_rsp_o,
    output evg_link_word_t link_o
);
    logic                 link_en;
    evg_seg_wr_t          seg_wr;
    evg_tp_ctrl_t         tp_ctrl;
    logic                 tp_pop;
    logic [`EVG_TP_W-1:0] tp_head;   // FIFO head word
    evg_tp_stat_t         tp_stat;

    // Register block
    evg_apb_regs u_regs (
        .clk       (clk),
        .rst       (rst),
        .apb_req_i (apb_req_i),
        .apb_rsp_o (apb_rsp_o),
        .link_en_o (link_en),
        .seg_wr_o  (seg_wr),
        .tp_ctrl_o (tp_ctrl),
        .tp_pop_o  (tp_pop),
        .tp_head_i (tp_head),
        .tp_stat_i (tp_stat)
    );

    evg_frame_gen u_frame (
        .clk       (clk),
        .rst       (rst),
        .link_en_i (link_en),
        .seg_wr_i  (seg_wr),
        .link_o    (link_o)
    );

    // Test pattern into FIFO
    evg_test_pattern u_tp (
        .clk    (clk),
        .rst    (rst),
        .ctrl_i (tp_ctrl),
        .pop_i  (tp_pop),
        .head_o (tp_head),
        .stat_o (tp_stat)
    );

endmodule

// ==== sim/evg_checker.sv ====
`timescale 1ns/1ps
`include "evg_defines.svh"

module evg_checker
    import evg_pkg::*;
(
    input logic           clk,
    input logic           rst,
    input evg_apb_req_t   apb_req_i,
    input evg_apb_rsp_t   apb_rsp_i,
    input evg_link_word_t link_i
);
    int unsigned          err_cnt  = 0;
    int unsigned          chk_cnt  = 0;
    int unsigned          link_cnt = 0;   // Framed words compared
    int unsigned          idle_cnt = 0;   // Zero words while link down
    logic [1:0]           ctrl_m;         // {test, link}
    logic [31:0]          presc_m;
    logic [31:0]          seg_m [`EVG_SEG_WORDS];
    logic [`EVG_TP_W-1:0] tp_next;        // Value the FIFO head should show
    int unsigned          occ_m;          // FIFO entries
    logic [31:0]          pre_m;          // Prescaler count
    logic                 link_on_d;      // Link enable as seen by link_o
    logic                 aligned;
    int unsigned          fidx;           // Frame index of the sampled word

    task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] got);
        chk_cnt++;
        if (exp !== got)
        begin
            err_cnt++;
            $display("[ERROR] %s exp %h got %h at %0t", name, exp, got, $time);
        end
    endtask

    function automatic logic [7:0] buf_byte(input int unsigned b);
        logic [31:0] w;
        w = seg_m[b / 4];
        return w[8 * (b % 4) +: 8];   // Byte 4n in the low lane
    endfunction

    // Link word for frame index i
    function automatic evg_link_word_t frame_word(input int unsigned i);
        evg_link_word_t w;
        w.data[15:8] = (i % 4 == 0) ? `EVG_K28_5 : 8'h00;
        w.data[7:0]  = (i % 2 == 1) ? buf_byte(i / 2) : 8'h00;
        w.is_k[1]    = (w.data[15:8] == `EVG_K28_5);
        w.is_k[0]    = (w.data[7:0] == `EVG_K_START) || (w.data[7:0] == `EVG_K_STOP);
        return w;
    endfunction

    function automatic logic exp_slverr(input evg_apb_req_t r);
        logic seg_hit;
        seg_hit = (r.paddr >= `EVG_REG_SEG_BASE)
               && (r.paddr < `EVG_REG_SEG_BASE + 4 * `EVG_SEG_WORDS)
               && (r.paddr[1:0] == 2'b00);
        if (r.paddr == `EVG_REG_STATUS || r.paddr == `EVG_REG_TP_DATA)
            return r.pwrite;   // Read only
        return !(seg_hit || r.paddr == `EVG_REG_CTRL || r.paddr == `EVG_REG_PRESC);
    endfunction

    always @(posedge clk)
    begin : model
        evg_link_word_t exp_w;
        logic [31:0]    exp_d;
        logic [31:0]    got;
        logic           err;
        logic           acc;
        logic           clr;
        logic           pop;
        logic           run;
        logic           push;
        int             n;
        int unsigned    i;
        if (rst)
        begin
            ctrl_m    <= '0;
            presc_m   <= '0;
            tp_next   <= '0;
            occ_m     <= 0;
            pre_m     <= '0;
            link_on_d <= 1'b0;
            aligned   <= 1'b0;
            fidx      <= 0;
            for (int w = 0; w < `EVG_SEG_WORDS; w++)
                seg_m[w] <= '0;
        end
        else
        begin
            link_on_d <= ctrl_m[0];   // link_o trails CTRL by two edges
            if (!link_on_d)
            begin
                aligned <= 1'b0;
                compare("link_o", 32'h0, 32'(link_i));
                idle_cnt++;
            end
            else if (aligned || link_i != '0)
            begin
                i     = aligned ? fidx : 0;   // First nonzero word is index 0
                exp_w = frame_word(i);
                compare("link_o event", {exp_w.is_k[1], exp_w.data[15:8]},
                        {link_i.is_k[1], link_i.data[15:8]});
                compare("link_o data", {exp_w.is_k[0], exp_w.data[7:0]},
                        {link_i.is_k[0], link_i.data[7:0]});
                aligned <= 1'b1;
                fidx    <= (i + 1) % `EVG_FRAME_LEN;
                link_cnt++;
            end

            // Test source and FIFO step on the state before the edge
            acc  = apb_req_i.psel && apb_req_i.penable;
            clr  = acc && apb_req_i.pwrite && (apb_req_i.paddr == `EVG_REG_CTRL)
                && apb_req_i.pwdata[2];
            pop  = acc && !apb_req_i.pwrite && (apb_req_i.paddr == `EVG_REG_TP_DATA)
                && (occ_m != 0);
            run  = ctrl_m[1] && !clr && (occ_m != `EVG_FIFO_DEPTH);   // Holds while full
            push = run && (pre_m == presc_m);                          // Every presc + 1 cycles
            if (clr)
            begin
                occ_m   <= 0;
                pre_m   <= '0;
                tp_next <= '0;        // Clear restarts the sequence
            end
            else
            begin
                if (run)
                    pre_m <= push ? 32'h0 : pre_m + 1;
                if (pop)
                    tp_next <= tp_next + 1'b1;
                occ_m <= occ_m + push - pop;
            end

            // Completed APB access
            if (acc)
            begin
                got = apb_rsp_i.prdata;
                err = exp_slverr(apb_req_i);
                n   = (int'(apb_req_i.paddr) - int'(`EVG_REG_SEG_BASE)) / 4;
                compare("pready", 32'h1, 32'(apb_rsp_i.pready));
                compare("pslverr", 32'(err), 32'(apb_rsp_i.pslverr));
                if (!err && apb_req_i.pwrite)
                begin
                    case (apb_req_i.paddr)
                        `EVG_REG_CTRL:  ctrl_m  <= apb_req_i.pwdata[1:0];
                        `EVG_REG_PRESC: presc_m <= apb_req_i.pwdata;
                        default:        seg_m[n] <= apb_req_i.pwdata;
                    endcase
                end
                else if (!err)
                begin
                    case (apb_req_i.paddr)
                        `EVG_REG_CTRL:  compare("prdata CTRL", 32'(ctrl_m), got);
                        `EVG_REG_PRESC: compare("prdata PRESC", presc_m, got);
                        `EVG_REG_STATUS:
                        begin
                            exp_d       = '0;
                            exp_d[12:8] = 5'(occ_m);
                            exp_d[1]    = (occ_m == `EVG_FIFO_DEPTH);   // Full flag
                            exp_d[0]    = (occ_m == 0);
                            compare("prdata STATUS", exp_d, got);
                        end
                        `EVG_REG_TP_DATA:
                        begin
                            exp_d = '0;   // Empty reads all zero
                            if (occ_m != 0)
                                exp_d = {1'b1, {(31 - `EVG_TP_W){1'b0}}, tp_next};
                            compare("prdata TP_DATA", exp_d, got);
                        end
                        default: compare("prdata SEG", seg_m[n], got);
                    endcase
                end
            end
        end
    end

endmodule

// ==== sim/tb_evg.sv ====
`timescale 1ns/1ps
`include "evg_defines.svh"

module tb_evg
    import evg_pkg::*;
();
    logic           clk = 1'b0;
    logic           rst;
    evg_apb_req_t   apb_req;
    evg_apb_rsp_t   apb_rsp;
    evg_link_word_t link;
    integer         seed;
    int unsigned    test_cnt  = 0;
    int unsigned    test_fail = 0;
    int unsigned    tmo_cnt   = 0;
    int unsigned    err_base  = 0;   // Errors before the running test

    always #50 clk = ~clk;   // 100 ns period

    evg_top dut (
        .clk       (clk),
        .rst       (rst),
        .apb_req_i (apb_req),
        .apb_rsp_o (apb_rsp),
        .link_o    (link)
    );

    evg_checker u_chk (
        .clk       (clk),
        .rst       (rst),
        .apb_req_i (apb_req),
        .apb_rsp_i (apb_rsp),
        .link_i    (link)
    );

    task automatic timed_out(input string what);
        tmo_cnt++;
        $display("Timeout waiting for %s", what);
    endtask

    // Starts and ends 1 ns after a rising edge
    task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata);
        int n;
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = wr;
        apb_req.paddr   = addr;
        apb_req.pwdata  = wdata;
        @(posedge clk);
        #1 apb_req.penable = 1'b1;   // Access phase
        n = 0;
        @(negedge clk);
        while (!apb_rsp.pready && n < 8)
        begin
            @(negedge clk);
            n++;
        end
        if (!apb_rsp.pready)
            timed_out("pready");
        rdata = apb_rsp.prdata;   // Mid-cycle, stable
        @(posedge clk);
        #1 apb_req = '0;
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
        logic [31:0] unused;
        apb_xfer(1'b1, addr, data, unused);
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
        apb_xfer(1'b0, addr, 32'h0, data);
    endtask

    task automatic idle(input int unsigned cycles);
        repeat (cycles) @(posedge clk);
        #1;
    endtask

    // Until the checker has compared enough link words
    task automatic wait_words(input bit idle_words, input int unsigned target);
        int unsigned t;
        t = 0;
        while ((idle_words ? u_chk.idle_cnt : u_chk.link_cnt) < target && t < 1000)
        begin
            @(negedge clk);
            t++;
        end
        if (t >= 1000)
            timed_out("link words");
        @(posedge clk);
        #1;
    endtask

    task automatic report_test(input string name);
        int unsigned errs;
        errs     = u_chk.err_cnt + tmo_cnt - err_base;
        err_base = u_chk.err_cnt + tmo_cnt;
        test_cnt++;
        if (errs != 0)
            test_fail++;
        $display("test %0d %s: %0d errors, %s", test_cnt, name, errs, errs ? "FAIL" : "ok");
    endtask

    initial
    begin
        logic [31:0] rd;
        logic [31:0] w;
        int unsigned n;
        int unsigned got;
        int unsigned t;
        seed    = 32'h9d90_c623;
        apb_req = '0;
        rst     = 1'b1;
        repeat (5) @(posedge clk);
        #1 rst = 1'b0;

        apb_read(`EVG_REG_STATUS, rd);          // Empty after reset
        apb_write(`EVG_REG_CTRL, 32'h3);
        apb_read(`EVG_REG_CTRL, rd);
        apb_write(`EVG_REG_CTRL, 32'h4);        // Clear, link and source off
        apb_read(`EVG_REG_CTRL, rd);
        apb_write(`EVG_REG_PRESC, $random(seed));
        apb_read(`EVG_REG_PRESC, rd);
        for (int k = 0; k < `EVG_SEG_WORDS; k++)
        begin
            w = $random(seed);
            if (k == 0)
                w[31:24] = `EVG_K_START;        // Buffer byte 3
            if (k == 5)
                w[7:0] = `EVG_K_STOP;           // Buffer byte 20
            apb_write(8'(`EVG_REG_SEG_BASE + 4 * k), w);
            apb_read(8'(`EVG_REG_SEG_BASE + 4 * k), rd);
        end
        apb_read(8'h10, rd);                    // Unmapped
        apb_read(8'h60, rd);                    // Past the SEG words
        apb_read(8'h41, rd);                    // Unaligned
        apb_write(`EVG_REG_STATUS, 32'hffff_ffff);
        apb_write(`EVG_REG_TP_DATA, 32'hffff_ffff);
        report_test("register access");

        n = u_chk.link_cnt;
        apb_write(`EVG_REG_CTRL, 32'h1);
        wait_words(1'b0, n + 2 * `EVG_FRAME_LEN);
        report_test("frame commas");

        n = u_chk.link_cnt;
        wait_words(1'b0, n + `EVG_FRAME_LEN);
        apb_write(`EVG_REG_CTRL, 32'h0);
        n = u_chk.idle_cnt;
        wait_words(1'b1, n + 8);                // Link back to zero
        report_test("frame data and flags");

        apb_write(`EVG_REG_PRESC, $random(seed) & 3);
        apb_write(`EVG_REG_CTRL, 32'h6);        // Clear and start the source
        rd = '0;
        t  = 0;
        while (!rd[1] && t < 200)
        begin
            apb_read(`EVG_REG_STATUS, rd);
            t++;
        end
        if (!rd[1])
            timed_out("STATUS full");
        idle(8);                                // Source holds while full
        got = 0;
        t   = 0;
        while (got < 40 && t < 400)
        begin
            apb_read(`EVG_REG_TP_DATA, rd);
            if (rd[31])
                got++;
            apb_read(`EVG_REG_STATUS, rd);
            idle(1 + ($random(seed) & 3));
            t++;
        end
        if (got < 40)
            timed_out("test values");
        report_test("test sequence and back-pressure");

        apb_write(`EVG_REG_CTRL, 32'h4);        // Clear with source off
        apb_read(`EVG_REG_TP_DATA, rd);
        apb_read(`EVG_REG_STATUS, rd);
        apb_write(`EVG_REG_CTRL, 32'h2);
        rd = '0;
        t  = 0;
        while (!rd[31] && t < 100)
        begin
            apb_read(`EVG_REG_TP_DATA, rd);
            t++;
        end
        if (!rd[31])
            timed_out("first value after clear");
        apb_write(`EVG_REG_CTRL, 32'h0);
        report_test("empty and clear");

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 test_cnt, test_fail, u_chk.chk_cnt, u_chk.err_cnt + tmo_cnt);
        if (test_fail == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+hdl
hdl/evg_pkg.sv
hdl/evg_sync_fifo.sv
hdl/evg_test_pattern.sv
hdl/evg_frame_gen.sv
hdl/evg_apb_regs.sv
hdl/evg_top.sv
sim/evg_checker.sv
sim/tb_evg.sv
